//--- src/memPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, MIPS memory opcodes, access sizes and the structs
// passed between execute, the memory stage, the data memory and WB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package memPkg;

    // datapath and address width
    localparam int dataWidth = 32;
    // register file index
    localparam int regAddrWidth = 5;
    // hazard timer
    localparam int tnewWidth = 2;

    // primary opcode field, bits 31..26
    localparam logic [5:0] opcLb  = 6'h20;
    localparam logic [5:0] opcLh  = 6'h21;
    localparam logic [5:0] opcLw  = 6'h23;
    localparam logic [5:0] opcLbu = 6'h24;
    localparam logic [5:0] opcLhu = 6'h25;
    localparam logic [5:0] opcSb  = 6'h28;
    localparam logic [5:0] opcSh  = 6'h29;
    localparam logic [5:0] opcSw  = 6'h2b;

    // access width codes
    localparam logic [1:0] sizeByte = 2'd0;
    localparam logic [1:0] sizeHalf = 2'd1;
    localparam logic [1:0] sizeWord = 2'd2;

    typedef enum logic [3:0] {
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opNone
    } memOpT;

    // decoded memory operation
    typedef struct packed {
        memOpT      op;
        logic       isLoad;
        logic       isStore;
        logic [1:0] size;
        logic       signedLoad;
    } accessT;

    // instruction record arriving from execute
    typedef struct packed {
        logic [dataWidth-1:0]    instr;
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    aluOut;
        logic [dataWidth-1:0]    dataRt;
        logic [regAddrWidth-1:0] addrRt;
        logic [regAddrWidth-1:0] regWriteAddr;
        logic [dataWidth-1:0]    regWriteData;
        logic [tnewWidth-1:0]    tnew;
    } memInT;

    // MEM/WB pipeline register contents
    typedef struct packed {
        logic [dataWidth-1:0]    instr;
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    memWord;
        logic [1:0]              offset;
        logic [regAddrWidth-1:0] regWriteAddr;
        logic [dataWidth-1:0]    regWriteData;
        logic [tnewWidth-1:0]    tnew;
    } wbT;

    // data memory request, word addressed
    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic [dataWidth-3:0] wordAddr;
        logic [dataWidth-1:0] wData;
        logic [3:0]           byteEn;
    } memReqT;

endpackage

`default_nettype wire

//--- src/memOpDecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory opcode decoder: op, load/store flags, width, signedness
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module memOpDecode
    import memPkg::*;
(
    input  logic [31:0] instr,
    output accessT      access
);

    logic [5:0] opcode;
    memOpT      op;

    assign opcode = instr[31:26];

    // only the eight load/store opcodes matter here
    always_comb begin
        case (opcode)
            opcLw:   op = opLw;
            opcLh:   op = opLh;
            opcLhu:  op = opLhu;
            opcLb:   op = opLb;
            opcLbu:  op = opLbu;
            opcSw:   op = opSw;
            opcSh:   op = opSh;
            opcSb:   op = opSb;
            default: op = opNone;
        endcase
    end

    always_comb begin
        access.op         = op;
        access.isLoad     = 1'b0;
        access.isStore    = 1'b0;
        access.size       = sizeWord;
        access.signedLoad = 1'b0;
        case (op)
            opLw: begin
                access.isLoad = 1'b1;
            end
            opLh: begin
                access.isLoad     = 1'b1;
                access.size       = sizeHalf;
                access.signedLoad = 1'b1;
            end
            opLhu: begin
                access.isLoad = 1'b1;
                access.size   = sizeHalf;
            end
            opLb: begin
                access.isLoad     = 1'b1;
                access.size       = sizeByte;
                access.signedLoad = 1'b1;
            end
            opLbu: begin
                access.isLoad = 1'b1;
                access.size   = sizeByte;
            end
            opSw: begin
                access.isStore = 1'b1;
            end
            opSh: begin
                access.isStore = 1'b1;
                access.size    = sizeHalf;
            end
            opSb: begin
                access.isStore = 1'b1;
                access.size    = sizeByte;
            end
            // non-memory instruction, flags stay clear
            default: begin
                access.isLoad = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/storeAlign.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address split, byte enables and lane placement of store data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module storeAlign
    import memPkg::*;
(
    input  accessT      access,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    input  logic [31:0] pc,
    output memReqT      memReq,
    output logic [1:0]  offset
);

    logic misaligned;

    // byte position inside the word
    assign offset = addr[1:0];

    always_comb begin
        memReq.pc       = pc;
        memReq.wordAddr = addr[31:2];
        memReq.wData    = wData;
        // nothing is written unless this is a store
        memReq.byteEn   = 4'b0000;
        if (access.isStore) begin
            case (access.size)
                sizeByte: begin
                    // one lane, data copied to all four
                    memReq.byteEn = 4'b0001 << addr[1:0];
                    memReq.wData  = {4{wData[7:0]}};
                end
                sizeHalf: begin
                    // lower or upper lane pair
                    memReq.byteEn = addr[1] ? 4'b1100 : 4'b0011;
                    memReq.wData  = {2{wData[15:0]}};
                end
                default: begin
                    memReq.byteEn = 4'b1111;
                end
            endcase
        end
    end

    // word needs offset 0, halfword an even offset
    always_comb begin
        misaligned = 1'b0;
        if (access.size == sizeWord) begin
            misaligned = (addr[1:0] != 2'd0);
        end else if (access.size == sizeHalf) begin
            misaligned = addr[0];
        end
    end

    alignCheck: assert final (!(access.isLoad || access.isStore) || !misaligned)
        else $error("misaligned access to %h, pc %h", addr, pc);

endmodule

`default_nettype wire

//--- src/memAccessStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM stage: store-data forwarding, decode and align, load select,
// Tnew update and the MEM/WB register with stall and clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module memAccessStage
    import memPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic        clr,
    input  memInT       memIn,
    input  logic [4:0]  fwdAddr,
    input  logic [31:0] fwdData,
    input  logic [31:0] rData,
    output memReqT      memReq,
    output wbT          wbOut
);

    accessT               access;
    logic [dataWidth-1:0] storeData;
    logic [1:0]           offset;
    logic [tnewWidth-1:0] tnewNext;
    wbT                   wbNext;

    // WB result bypass onto the store data, r0 never forwards
    assign storeData = ((fwdAddr == memIn.addrRt) && (fwdAddr != '0)) ?
                       fwdData : memIn.dataRt;

    memOpDecode opDecode (
        .instr  (memIn.instr),
        .access (access)
    );

    storeAlign align (
        .access (access),
        .addr   (memIn.aluOut),
        .wData  (storeData),
        .pc     (memIn.pc),
        .memReq (memReq),
        .offset (offset)
    );

    // one cycle closer to ready, stops at zero
    assign tnewNext = (memIn.tnew != '0) ? memIn.tnew - 1'b1 : '0;

    always_comb begin
        wbNext.instr        = memIn.instr;
        wbNext.pc           = memIn.pc;
        wbNext.memWord      = rData;
        wbNext.offset       = offset;
        wbNext.regWriteAddr = memIn.regWriteAddr;
        // loads take the raw memory word, extension happens in WB
        wbNext.regWriteData = access.isLoad ? rData : memIn.regWriteData;
        wbNext.tnew         = tnewNext;
    end

    // MEM/WB register, clr beats stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbOut <= '0;
        end else if (clr) begin
            wbOut <= '0;
        end else if (!stall) begin
            wbOut <= wbNext;
        end
    end

    // pipeline controls come from hazard logic
    ctrlKnown: assert property (
        @(posedge clk) disable iff (!arstN) !$isunknown({stall, clr})
    ) else $error("stall or clr unknown out of reset");

endmodule

`default_nettype wire

//--- src/dataMemory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word-organised data memory, async read, byte-enabled clocked write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module dataMemory
    import memPkg::*;
#(
    parameter int memDepthWords = 1024
) (
    input  logic        clk,
    input  memReqT      memReq,
    output logic [31:0] rData
);

    // index bits for a power-of-two depth
    localparam int idxWidth = $clog2(memDepthWords);

    logic [dataWidth-1:0] mem [memDepthWords];
    logic [idxWidth-1:0]  idx;

    // address wraps on the low word-address bits
    assign idx = memReq.wordAddr[idxWidth-1:0];

    // same-cycle read for the stage
    assign rData = mem[idx];

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (memReq.byteEn[b]) begin
                mem[idx][8*b +: 8] <= memReq.wData[8*b +: 8];
            end
        end
    end

    // a write above the array would silently alias a lower word
    inRange: assert property (
        @(posedge clk) (memReq.byteEn != 4'b0000) |-> (memReq.wordAddr < memDepthWords)
    ) else $error("write beyond memory, word %h, pc %h", memReq.wordAddr, memReq.pc);

endmodule

`default_nettype wire

//--- src/loadExtend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback load extraction with sign or zero extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module loadExtend
    import memPkg::*;
(
    input  wbT          wbIn,
    output logic [4:0]  regAddr,
    output logic [31:0] regData
);

    accessT      access;
    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // decoded again here from the registered instruction
    memOpDecode opDecode (
        .instr  (wbIn.instr),
        .access (access)
    );

    assign regAddr = wbIn.regWriteAddr;

    // lane pick by offset
    always_comb begin
        case (wbIn.offset)
            2'd0:    byteSel = wbIn.memWord[7:0];
            2'd1:    byteSel = wbIn.memWord[15:8];
            2'd2:    byteSel = wbIn.memWord[23:16];
            default: byteSel = wbIn.memWord[31:24];
        endcase
        halfSel = wbIn.offset[1] ? wbIn.memWord[31:16] : wbIn.memWord[15:0];
    end

    always_comb begin
        // non-loads keep the ALU or link result
        regData = wbIn.regWriteData;
        if (access.isLoad) begin
            case (access.size)
                sizeByte: begin
                    regData = access.signedLoad ?
                              {{(dataWidth-8){byteSel[7]}}, byteSel} :
                              {{(dataWidth-8){1'b0}}, byteSel};
                end
                sizeHalf: begin
                    regData = access.signedLoad ?
                              {{(dataWidth-16){halfSel[15]}}, halfSel} :
                              {{(dataWidth-16){1'b0}}, halfSel};
                end
                default: begin
                    regData = wbIn.memWord;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/memSubsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level: MEM stage, data memory, WB extension, forwarding loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module memSubsystem
    import memPkg::*;
#(
    parameter int memDepthWords = 1024
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic        clr,
    input  memInT       memIn,
    output wbT          wbOut,
    output logic [4:0]  wbRegAddr,
    output logic [31:0] wbRegData
);

    // stage to memory
    memReqT               memReq;
    logic [dataWidth-1:0] rData;

    // writeback value loops back as the forwarding source
    memAccessStage stage (
        .clk     (clk),
        .arstN   (arstN),
        .stall   (stall),
        .clr     (clr),
        .memIn   (memIn),
        .fwdAddr (wbRegAddr),
        .fwdData (wbRegData),
        .rData   (rData),
        .memReq  (memReq),
        .wbOut   (wbOut)
    );

    dataMemory #(
        .memDepthWords (memDepthWords)
    ) dmem (
        .clk    (clk),
        .memReq (memReq),
        .rData  (rData)
    );

    // purely combinational from the registered record
    loadExtend wbExtend (
        .wbIn    (wbOut),
        .regAddr (wbRegAddr),
        .regData (wbRegData)
    );

endmodule

`default_nettype wire

//--- bench/memSubsystemTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory subsystem: clock, reset, LFSR, shadow
// memory model, compare tasks and directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module memSubsystemTb
    import memPkg::*;
();

    localparam int memDepth = 1024;
    localparam int memBytes = 4 * memDepth;

    logic        clk;
    logic        arstN;
    logic        stall;
    logic        clr;
    memInT       memIn;
    wbT          wbOut;
    logic [4:0]  wbRegAddr;
    logic [31:0] wbRegData;

    // reference state: byte image of memory and expected MEM/WB record
    logic [7:0]  shadow [memBytes];
    wbT          expWb;
    logic [31:0] lfsrState;
    logic [31:0] pcCount;
    logic [31:0] roundAddr [8];
    int          wbErrors;
    int          regErrors;
    int          timeoutErrors;

    memSubsystem #(
        .memDepthWords (memDepth)
    ) UUT (
        .clk       (clk),
        .arstN     (arstN),
        .stall     (stall),
        .clr       (clr),
        .memIn     (memIn),
        .wbOut     (wbOut),
        .wbRegAddr (wbRegAddr),
        .wbRegData (wbRegData)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // MIPS primary opcodes, anything else is an R-type
    function automatic logic [5:0] opcodeOf(input memOpT op);
        case (op)
            opLb:    return 6'h20;
            opLh:    return 6'h21;
            opLw:    return 6'h23;
            opLbu:   return 6'h24;
            opLhu:   return 6'h25;
            opSb:    return 6'h28;
            opSh:    return 6'h29;
            opSw:    return 6'h2b;
            default: return 6'h00;
        endcase
    endfunction

    // little-endian word view of the shadow bytes
    function automatic logic [31:0] shadowWord(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00} % memBytes;
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    // final register value after the WB load rules
    function automatic logic [31:0] expectRegData(input wbT w);
        logic [31:0] lane;
        lane = w.memWord >> (8 * w.offset);
        case (w.instr[31:26])
            6'h20:   return {{24{lane[7]}}, lane[7:0]};
            6'h24:   return {24'h0, lane[7:0]};
            6'h21:   return {{16{lane[15]}}, lane[15:0]};
            6'h25:   return {16'h0, lane[15:0]};
            6'h23:   return w.memWord;
            default: return w.regWriteData;
        endcase
    endfunction

    task automatic checkWb(input wbT got, input wbT exp, input string what);
        if (got !== exp) begin
            wbErrors++;
            $display("ERROR at %0t: %s wbOut %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkReg(input logic [4:0] gotAddr, input logic [31:0] gotData,
                            input logic [4:0] expAddr, input logic [31:0] expData,
                            input string what);
        if (gotAddr !== expAddr || gotData !== expData) begin
            regErrors++;
            $display("ERROR at %0t: %s writeback r%0d=%h, expected r%0d=%h",
                     $time, what, gotAddr, gotData, expAddr, expData);
        end
    endtask

    // called on a falling edge
    task automatic driveInstr(input memOpT op, input logic [4:0] rt, input logic [4:0] dest,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] tnew);
        memInT rec;
        pcCount = pcCount + 32'd4;
        rec.instr        = {opcodeOf(op), 5'd29, rt, addr[15:0]};
        rec.pc           = pcCount;
        rec.aluOut       = addr;
        rec.dataRt       = data;
        rec.addrRt       = rt;
        rec.regWriteAddr = dest;
        rec.regWriteData = data;
        rec.tnew         = tnew;
        memIn = rec;
    endtask

    // drive one instruction, predict the edge, check at the next falling edge
    task automatic runInstr(input memOpT op, input logic [4:0] rt, input logic [4:0] dest,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [1:0] tnew);
        wbT          next;
        logic [31:0] fwdVal;
        logic [31:0] wordBase;
        driveInstr(op, rt, dest, addr, data, tnew);
        // store data bypass from the result now in WB
        fwdVal = data;
        if (rt != 5'd0 && expWb.regWriteAddr == rt) begin
            fwdVal = expectRegData(expWb);
        end
        next.instr        = memIn.instr;
        next.pc           = memIn.pc;
        next.memWord      = shadowWord(addr);
        next.offset       = addr[1:0];
        next.regWriteAddr = dest;
        // loads are opcodes 100xxx
        next.regWriteData = (memIn.instr[31:29] == 3'b100) ? next.memWord : data;
        next.tnew         = (tnew == 2'd0) ? 2'd0 : tnew - 2'd1;
        // write lands on this edge even under stall
        wordBase = {addr[31:2], 2'b00};
        case (op)
            opSw: begin
                for (int b = 0; b < 4; b++) begin
                    shadow[wordBase + b] = fwdVal[8*b +: 8];
                end
            end
            opSh: begin
                shadow[addr]     = fwdVal[7:0];
                shadow[addr + 1] = fwdVal[15:8];
            end
            opSb: begin
                shadow[addr] = fwdVal[7:0];
            end
            default: begin
            end
        endcase
        if (clr) begin
            expWb = '0;
        end else if (!stall) begin
            expWb = next;
        end
        @(negedge clk);
        checkWb(wbOut, expWb, op.name());
        checkReg(wbRegAddr, wbRegData, expWb.regWriteAddr, expectRegData(expWb), op.name());
    endtask

    task automatic waitWbCleared(input int maxCycles);
        int n;
        n = 0;
        while (wbOut !== '0 && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (wbOut !== '0) begin
            timeoutErrors++;
            $display("timeout: wbOut still not cleared %0d cycles into reset", maxCycles);
        end
    endtask

    // 8 cycles low, released on a falling edge
    task automatic applyReset();
        arstN = 1'b0;
        #1;
        waitWbCleared(2);
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkWb(wbOut, '0, "reset");
        end
        arstN = 1'b1;
        expWb = '0;
    endtask

    task automatic testWordRoundTrip();
        logic [31:0] word [8];
        // distinct aligned addresses, one per 512-byte block
        for (int i = 0; i < 8; i++) begin
            roundAddr[i] = (i << 9) | (randBits(7) << 2);
            word[i] = randBits(32);
            runInstr(opSw, 5'd8, 5'd0, roundAddr[i], word[i], randBits(2));
        end
        for (int i = 0; i < 8; i++) begin
            runInstr(opLw, 5'd0, 5'd9, roundAddr[i], 32'h0, randBits(2));
            checkReg(wbRegAddr, wbRegData, 5'd9, word[i], "lw round trip");
        end
    endtask

    task automatic testSubWord();
        logic [31:0] base;
        logic [31:0] data;
        base = 32'h800 | (randBits(8) << 2);
        runInstr(opSw, 5'd8, 5'd0, base, randBits(32), randBits(2));
        // odd offsets get a negative byte
        for (int off = 0; off < 4; off++) begin
            data = randBits(32);
            data[7] = (off % 2 == 1);
            runInstr(opSb, 5'd8, 5'd0, base + off, data, randBits(2));
            runInstr(opLb, 5'd0, 5'd10, base + off, 32'h0, randBits(2));
            runInstr(opLbu, 5'd0, 5'd10, base + off, 32'h0, randBits(2));
            runInstr(opLw, 5'd0, 5'd10, base, 32'h0, randBits(2));
        end
        for (int off = 0; off < 4; off += 2) begin
            data = randBits(32);
            data[15] = (off == 2);
            runInstr(opSh, 5'd8, 5'd0, base + off, data, randBits(2));
            runInstr(opLh, 5'd0, 5'd11, base + off, 32'h0, randBits(2));
            runInstr(opLhu, 5'd0, 5'd11, base + off, 32'h0, randBits(2));
            runInstr(opLw, 5'd0, 5'd11, base, 32'h0, randBits(2));
        end
    endtask

    task automatic testForwarding();
        logic [31:0] a;
        logic [31:0] v;
        a = 32'hc00 | (randBits(7) << 2);
        v = randBits(32);
        // ALU result for r12 feeds the next store
        runInstr(opNone, 5'd0, 5'd12, a, v, randBits(2));
        runInstr(opSw, 5'd12, 5'd0, a, ~v, randBits(2));
        runInstr(opLw, 5'd0, 5'd9, a, 32'h0, randBits(2));
        checkReg(wbRegAddr, wbRegData, 5'd9, v, "sw after ALU result");
        // extended lb result feeds the store
        runInstr(opSb, 5'd8, 5'd0, a + 1, 32'h0000_0090, 2'd0);
        runInstr(opLb, 5'd0, 5'd13, a + 1, 32'h0, 2'd0);
        runInstr(opSw, 5'd13, 5'd0, a + 4, randBits(32), 2'd0);
        runInstr(opLw, 5'd0, 5'd9, a + 4, 32'h0, 2'd0);
        checkReg(wbRegAddr, wbRegData, 5'd9, 32'hffff_ff90, "sw after lb");
        // r0 is never a bypass source
        runInstr(opNone, 5'd0, 5'd0, a, v, 2'd0);
        runInstr(opSw, 5'd0, 5'd0, a + 8, ~v, 2'd0);
        runInstr(opLw, 5'd0, 5'd9, a + 8, 32'h0, 2'd0);
        checkReg(wbRegAddr, wbRegData, 5'd9, ~v, "sw from r0");
    endtask

    task automatic testStallClear();
        logic [31:0] a;
        logic [31:0] stallWord;
        a = 32'h400 | (randBits(8) << 2);
        stallWord = randBits(32);
        runInstr(opNone, 5'd0, 5'd14, a, randBits(32), 2'd3);
        // wbOut frozen while memIn moves on
        stall = 1'b1;
        runInstr(opSw, 5'd8, 5'd0, a, stallWord, 2'd1);
        runInstr(opNone, 5'd3, 5'd15, a, randBits(32), 2'd2);
        runInstr(opLhu, 5'd0, 5'd16, a, 32'h0, 2'd0);
        stall = 1'b0;
        runInstr(opLw, 5'd0, 5'd9, a, 32'h0, 2'd1);
        checkReg(wbRegAddr, wbRegData, 5'd9, stallWord, "store under stall");
        clr = 1'b1;
        runInstr(opNone, 5'd0, 5'd17, a, randBits(32), 2'd3);
        clr = 1'b0;
        runInstr(opNone, 5'd0, 5'd18, a, randBits(32), 2'd3);
        // clr wins over stall
        clr = 1'b1;
        stall = 1'b1;
        runInstr(opNone, 5'd0, 5'd19, a, randBits(32), 2'd2);
        clr = 1'b0;
        stall = 1'b0;
        runInstr(opNone, 5'd0, 5'd19, a, randBits(32), 2'd2);
        // memory survives a reset in mid-run
        applyReset();
        runInstr(opLw, 5'd0, 5'd9, a, 32'h0, 2'd0);
        checkReg(wbRegAddr, wbRegData, 5'd9, stallWord, "lw after reset");
    endtask

    task automatic testPassThrough();
        // nops aimed at written words, tnew walks 0..3 twice
        for (int t = 0; t < 8; t++) begin
            runInstr(opNone, 5'(randBits(5)), 5'd20 + 5'(t), roundAddr[t], randBits(32),
                     2'(t));
        end
        for (int i = 0; i < 8; i++) begin
            runInstr(opLw, 5'd0, 5'd9, roundAddr[i], 32'h0, 2'd0);
        end
    endtask

    initial begin
        arstN = 1'b0;
        stall = 1'b0;
        clr = 1'b0;
        memIn = '0;
        expWb = '0;
        lfsrState = 32'h2623_19c3;
        pcCount = 32'h0040_0000;
        wbErrors = 0;
        regErrors = 0;
        timeoutErrors = 0;
        applyReset();
        testWordRoundTrip();
        testSubWord();
        testForwarding();
        testStallClear();
        testPassThrough();
        $display("summary: %0d wbOut mismatches, %0d writeback mismatches, %0d timeouts",
                 wbErrors, regErrors, timeoutErrors);
        if (wbErrors + regErrors + timeoutErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // hang guard for the whole run
    initial begin
        #200000;
        $display("timeout: simulation ran past its time limit");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- memStage.f
src/memPkg.sv
src/memOpDecode.sv
src/storeAlign.sv
src/memAccessStage.sv
src/dataMemory.sv
src/loadExtend.sv
src/memSubsystem.sv
bench/memSubsystemTb.sv
